// File: hdl/axi_err_cfg.svh
`ifndef AXI_ERR_CFG_SVH
`define AXI_ERR_CFG_SVH

// --------------------------------------------------
// axi channel widths
// --------------------------------------------------
// id width on aw, b, ar and r
`define AXI_ID_W 4
// read data width, also the register port width
`define AXI_DATA_W 32
// axlen field
`define AXI_LEN_W 8

// --------------------------------------------------
// queues and registers
// --------------------------------------------------
// bursts accepted ahead on aw and ar
`define ERR_MAX_TRANS 4
`define CSR_CNT_W 16
`define CSR_ADDR_W 2
// fill word seen on every r beat after reset
`define ERR_FILL_RST 32'hBADCAB1E

`endif

// File: hdl/axi_err_pkg.sv
`default_nettype none

`include "axi_err_cfg.svh"

package axi_err_pkg;

  // --------------------------------------------------
  // axi response codes
  // --------------------------------------------------
  // bresp / rresp encoding
  typedef enum logic [1:0] {
    OKAY   = 2'b00,
    EXOKAY = 2'b01,
    SLVERR = 2'b10,
    DECERR = 2'b11
  } axi_resp_e;

  // --------------------------------------------------
  // register map
  // --------------------------------------------------
  // fill word, write error count, read error count
  typedef enum logic [`CSR_ADDR_W-1:0] {
    CSR_FILL = 2'd0,
    CSR_WCNT = 2'd1,
    CSR_RCNT = 2'd2
  } csr_addr_e;

endpackage

`default_nettype wire

// File: hdl/err_fifo.sv
`timescale 1ns/1ps
`default_nettype none

module err_fifo #(
  parameter int unsigned DATA_W = 8,
  parameter int unsigned DEPTH  = 4
) (
  input  wire logic              clk_i,
  input  wire logic              rst_ni,
  input  wire logic              push_i,
  input  wire logic [DATA_W-1:0] data_i,
  input  wire logic              pop_i,
  output logic      [DATA_W-1:0] data_o,
  output logic                   full_o,
  output logic                   empty_o
);
  // pointer and occupancy widths
  localparam int unsigned PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
  localparam int unsigned CNT_W = $clog2(DEPTH + 1);

  logic [DATA_W-1:0] mem_q [DEPTH];
  logic [PTR_W-1:0]  wr_ptr_q;
  logic [PTR_W-1:0]  rd_ptr_q;
  logic [CNT_W-1:0]  cnt_q;
  logic              push_ok;
  logic              pop_ok;

  assign full_o  = (cnt_q == CNT_W'(DEPTH));
  assign empty_o = (cnt_q == '0);
  // oldest entry
  assign data_o  = mem_q[rd_ptr_q];

  // overflow and underflow requests dropped here
  assign push_ok = push_i && !full_o;
  assign pop_ok  = pop_i && !empty_o;

  // storage, payload only
  always_ff @(posedge clk_i) begin
    if (push_ok) begin
      mem_q[wr_ptr_q] <= data_i;
    end
  end

  // pointers wrap at depth-1
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      cnt_q    <= '0;
    end else begin
      if (push_ok) begin
        wr_ptr_q <= (wr_ptr_q == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr_q + 1'b1;
      end
      if (pop_ok) begin
        rd_ptr_q <= (rd_ptr_q == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr_q + 1'b1;
      end
      // simultaneous push and pop keep the count
      if (push_ok && !pop_ok) begin
        cnt_q <= cnt_q + 1'b1;
      end else if (pop_ok && !push_ok) begin
        cnt_q <= cnt_q - 1'b1;
      end
    end
  end

endmodule

`default_nettype wire

// File: hdl/err_write_path.sv
`timescale 1ns/1ps
`default_nettype none

`include "axi_err_cfg.svh"

module err_write_path (
  input  wire logic                     clk_i,
  input  wire logic                     rst_ni,
  // aw channel
  input  wire logic                     aw_valid_i,
  output logic                          aw_ready_o,
  input  wire logic [`AXI_ID_W-1:0]     aw_id_i,
  // burst length not needed, w_last marks the end
  input  wire logic [`AXI_LEN_W-1:0]    aw_len_i,
  // w channel, data dropped
  input  wire logic                     w_valid_i,
  output logic                          w_ready_o,
  input  wire logic [`AXI_DATA_W-1:0]   w_data_i,
  input  wire logic                     w_last_i,
  // b channel
  output logic                          b_valid_o,
  input  wire logic                     b_ready_i,
  output logic      [`AXI_ID_W-1:0]     b_id_o,
  output axi_err_pkg::axi_resp_e        b_resp_o,
  // one pulse per b handshake
  output logic                          b_done_o
);
  // aw id queue
  logic                 aw_push;
  logic                 aw_pop;
  logic                 aw_full;
  logic                 aw_empty;
  logic [`AXI_ID_W-1:0] aw_head_id;
  // b id queue
  logic                 b_push;
  logic                 b_pop;
  logic                 b_full;
  logic                 b_empty;
  logic                 w_last_hs;

  // --------------------------------------------------
  // aw channel
  // --------------------------------------------------
  assign aw_ready_o = !aw_full;
  assign aw_push    = aw_valid_i && !aw_full;

  err_fifo #(
    .DATA_W ( `AXI_ID_W      ),
    .DEPTH  ( `ERR_MAX_TRANS )
  ) u_aw_fifo (
    .clk_i   ( clk_i      ),
    .rst_ni  ( rst_ni     ),
    .push_i  ( aw_push    ),
    .data_i  ( aw_id_i    ),
    .pop_i   ( aw_pop     ),
    .data_o  ( aw_head_id ),
    .full_o  ( aw_full    ),
    .empty_o ( aw_empty   )
  );

  // --------------------------------------------------
  // w channel sink
  // --------------------------------------------------
  // eat beats while an id waits and b has room
  assign w_ready_o = !aw_empty && !b_full;
  // last beat moves the id over to the b queue
  assign w_last_hs = w_valid_i && w_ready_o && w_last_i;
  assign aw_pop    = w_last_hs;
  assign b_push    = w_last_hs;

  // two entries so w keeps flowing when b stalls
  err_fifo #(
    .DATA_W ( `AXI_ID_W ),
    .DEPTH  ( 2         )
  ) u_b_fifo (
    .clk_i   ( clk_i      ),
    .rst_ni  ( rst_ni     ),
    .push_i  ( b_push     ),
    .data_i  ( aw_head_id ),
    .pop_i   ( b_pop      ),
    .data_o  ( b_id_o     ),
    .full_o  ( b_full     ),
    .empty_o ( b_empty    )
  );

  // --------------------------------------------------
  // b channel
  // --------------------------------------------------
  // head of the b queue, held until taken
  assign b_valid_o = !b_empty;
  assign b_resp_o  = axi_err_pkg::DECERR;
  assign b_pop     = b_valid_o && b_ready_i;
  assign b_done_o  = b_pop;

endmodule

`default_nettype wire

// File: hdl/err_read_path.sv
`timescale 1ns/1ps
`default_nettype none

`include "axi_err_cfg.svh"

module err_read_path (
  input  wire logic                     clk_i,
  input  wire logic                     rst_ni,
  // ar channel
  input  wire logic                     ar_valid_i,
  output logic                          ar_ready_o,
  input  wire logic [`AXI_ID_W-1:0]     ar_id_i,
  input  wire logic [`AXI_LEN_W-1:0]    ar_len_i,
  // r channel
  output logic                          r_valid_o,
  input  wire logic                     r_ready_i,
  output logic      [`AXI_ID_W-1:0]     r_id_o,
  output logic      [`AXI_DATA_W-1:0]   r_data_o,
  output axi_err_pkg::axi_resp_e        r_resp_o,
  output logic                          r_last_o,
  // fill word from the register block
  input  wire logic [`AXI_DATA_W-1:0]   fill_i,
  // pulse on the last beat handshake
  output logic                          r_done_o
);
  localparam int unsigned AR_W = `AXI_ID_W + `AXI_LEN_W;

  // ar queue, id above len
  logic                  ar_push;
  logic                  ar_pop;
  logic                  ar_full;
  logic                  ar_empty;
  logic [AR_W-1:0]       ar_head;
  logic [`AXI_ID_W-1:0]  head_id;
  logic [`AXI_LEN_W-1:0] head_len;
  // burst state
  logic                  busy_q;
  logic [`AXI_LEN_W-1:0] beat_q;
  logic                  r_hs;
  logic                  last_beat;

  // --------------------------------------------------
  // ar channel
  // --------------------------------------------------
  assign ar_ready_o = !ar_full;
  assign ar_push    = ar_valid_i && !ar_full;

  err_fifo #(
    .DATA_W ( AR_W           ),
    .DEPTH  ( `ERR_MAX_TRANS )
  ) u_ar_fifo (
    .clk_i   ( clk_i                ),
    .rst_ni  ( rst_ni               ),
    .push_i  ( ar_push              ),
    .data_i  ( {ar_id_i, ar_len_i}  ),
    .pop_i   ( ar_pop               ),
    .data_o  ( ar_head              ),
    .full_o  ( ar_full              ),
    .empty_o ( ar_empty             )
  );

  assign head_id  = ar_head[AR_W-1:`AXI_LEN_W];
  assign head_len = ar_head[`AXI_LEN_W-1:0];

  // --------------------------------------------------
  // r beat generation
  // --------------------------------------------------
  // counter at zero means final beat
  assign last_beat = (beat_q == '0);
  assign r_hs      = busy_q && r_ready_i;

  assign r_valid_o = busy_q;
  assign r_id_o    = head_id;
  assign r_data_o  = fill_i;
  assign r_resp_o  = axi_err_pkg::DECERR;
  assign r_last_o  = busy_q && last_beat;

  // burst retires with its last beat
  assign ar_pop   = r_hs && last_beat;
  assign r_done_o = ar_pop;

  // idle -> load len, busy -> count down per accepted beat
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      busy_q <= 1'b0;
      beat_q <= '0;
    end else if (!busy_q) begin
      if (!ar_empty) begin
        busy_q <= 1'b1;
        beat_q <= head_len;
      end
    end else if (r_hs) begin
      if (last_beat) begin
        // one idle cycle before the next burst
        busy_q <= 1'b0;
      end else begin
        beat_q <= beat_q - 1'b1;
      end
    end
  end

endmodule

`default_nettype wire

// File: hdl/err_csr.sv
`timescale 1ns/1ps
`default_nettype none

`include "axi_err_cfg.svh"

module err_csr (
  input  wire logic                     clk_i,
  input  wire logic                     rst_ni,
  // register port
  input  wire logic [`CSR_ADDR_W-1:0]   reg_addr_i,
  input  wire logic [`AXI_DATA_W-1:0]   reg_wdata_i,
  input  wire logic                     reg_we_i,
  output logic      [`AXI_DATA_W-1:0]   reg_rdata_o,
  // completion pulses from the channel paths
  input  wire logic                     b_done_i,
  input  wire logic                     r_done_i,
  // fill word to the read path
  output logic      [`AXI_DATA_W-1:0]   fill_o
);
  localparam int unsigned PAD_W = `AXI_DATA_W - `CSR_CNT_W;

  axi_err_pkg::csr_addr_e addr;
  logic [`AXI_DATA_W-1:0] fill_q;
  logic [`CSR_CNT_W-1:0]  wcnt_q;
  logic [`CSR_CNT_W-1:0]  rcnt_q;
  logic                   we_fill;
  logic                   clr_wcnt;
  logic                   clr_rcnt;

  // --------------------------------------------------
  // write decode
  // --------------------------------------------------
  assign addr     = axi_err_pkg::csr_addr_e'(reg_addr_i);
  assign we_fill  = reg_we_i && (addr == axi_err_pkg::CSR_FILL);
  // any value written clears the counter
  assign clr_wcnt = reg_we_i && (addr == axi_err_pkg::CSR_WCNT);
  assign clr_rcnt = reg_we_i && (addr == axi_err_pkg::CSR_RCNT);

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      fill_q <= `ERR_FILL_RST;
      wcnt_q <= '0;
      rcnt_q <= '0;
    end else begin
      if (we_fill) begin
        fill_q <= reg_wdata_i;
      end
      // clear beats a same-cycle done pulse
      if (clr_wcnt) begin
        wcnt_q <= '0;
      end else if (b_done_i && (wcnt_q != '1)) begin
        wcnt_q <= wcnt_q + 1'b1;
      end
      // saturate at all ones
      if (clr_rcnt) begin
        rcnt_q <= '0;
      end else if (r_done_i && (rcnt_q != '1)) begin
        rcnt_q <= rcnt_q + 1'b1;
      end
    end
  end

  assign fill_o = fill_q;

  // --------------------------------------------------
  // read mux
  // --------------------------------------------------
  always_comb begin
    case (addr)
      axi_err_pkg::CSR_FILL: reg_rdata_o = fill_q;
      axi_err_pkg::CSR_WCNT: reg_rdata_o = {{PAD_W{1'b0}}, wcnt_q};
      axi_err_pkg::CSR_RCNT: reg_rdata_o = {{PAD_W{1'b0}}, rcnt_q};
      // unused address
      default:               reg_rdata_o = '0;
    endcase
  end

endmodule

`default_nettype wire

// File: hdl/axi_decerr_sub.sv
`timescale 1ns/1ps
`default_nettype none

`include "axi_err_cfg.svh"

module axi_decerr_sub (
  input  wire logic                     clk_i,
  input  wire logic                     rst_ni,
  // aw
  input  wire logic                     aw_valid_i,
  output logic                          aw_ready_o,
  input  wire logic [`AXI_ID_W-1:0]     aw_id_i,
  input  wire logic [`AXI_LEN_W-1:0]    aw_len_i,
  // w
  input  wire logic                     w_valid_i,
  output logic                          w_ready_o,
  input  wire logic [`AXI_DATA_W-1:0]   w_data_i,
  input  wire logic                     w_last_i,
  // b
  output logic                          b_valid_o,
  input  wire logic                     b_ready_i,
  output logic      [`AXI_ID_W-1:0]     b_id_o,
  output axi_err_pkg::axi_resp_e        b_resp_o,
  // ar
  input  wire logic                     ar_valid_i,
  output logic                          ar_ready_o,
  input  wire logic [`AXI_ID_W-1:0]     ar_id_i,
  input  wire logic [`AXI_LEN_W-1:0]    ar_len_i,
  // r
  output logic                          r_valid_o,
  input  wire logic                     r_ready_i,
  output logic      [`AXI_ID_W-1:0]     r_id_o,
  output logic      [`AXI_DATA_W-1:0]   r_data_o,
  output axi_err_pkg::axi_resp_e        r_resp_o,
  output logic                          r_last_o,
  // register port
  input  wire logic [`CSR_ADDR_W-1:0]   reg_addr_i,
  input  wire logic [`AXI_DATA_W-1:0]   reg_wdata_i,
  input  wire logic                     reg_we_i,
  output logic      [`AXI_DATA_W-1:0]   reg_rdata_o
);
  // completions into the counters, fill word out
  logic                   b_done;
  logic                   r_done;
  logic [`AXI_DATA_W-1:0] fill;

  // --------------------------------------------------
  // write side
  // --------------------------------------------------
  err_write_path u_write_path (
    .clk_i      ( clk_i      ), .rst_ni    ( rst_ni    ),
    .aw_valid_i ( aw_valid_i ), .aw_ready_o ( aw_ready_o ),
    .aw_id_i    ( aw_id_i    ), .aw_len_i  ( aw_len_i  ),
    .w_valid_i  ( w_valid_i  ), .w_ready_o ( w_ready_o ),
    .w_data_i   ( w_data_i   ), .w_last_i  ( w_last_i  ),
    .b_valid_o  ( b_valid_o  ), .b_ready_i ( b_ready_i ),
    .b_id_o     ( b_id_o     ), .b_resp_o  ( b_resp_o  ),
    .b_done_o   ( b_done     )
  );

  // --------------------------------------------------
  // read side
  // --------------------------------------------------
  err_read_path u_read_path (
    .clk_i      ( clk_i      ), .rst_ni     ( rst_ni     ),
    .ar_valid_i ( ar_valid_i ), .ar_ready_o ( ar_ready_o ),
    .ar_id_i    ( ar_id_i    ), .ar_len_i   ( ar_len_i   ),
    .r_valid_o  ( r_valid_o  ), .r_ready_i  ( r_ready_i  ),
    .r_id_o     ( r_id_o     ), .r_data_o   ( r_data_o   ),
    .r_resp_o   ( r_resp_o   ), .r_last_o   ( r_last_o   ),
    .fill_i     ( fill       ), .r_done_o   ( r_done     )
  );

  // fill word and error counters
  err_csr u_csr (
    .clk_i       ( clk_i       ),
    .rst_ni      ( rst_ni      ),
    .reg_addr_i  ( reg_addr_i  ),
    .reg_wdata_i ( reg_wdata_i ),
    .reg_we_i    ( reg_we_i    ),
    .reg_rdata_o ( reg_rdata_o ),
    .b_done_i    ( b_done      ),
    .r_done_i    ( r_done      ),
    .fill_o      ( fill        )
  );

endmodule

`default_nettype wire

// File: tests/tb_axi_decerr_sub.sv
`timescale 1ns/1ps
`default_nettype none

`include "axi_err_cfg.svh"

module tb_axi_decerr_sub;

  localparam int N_WR    = 200;
  localparam int N_RD    = 200;
  localparam int MAX_LEN = 15;
  // 40 cycles for each worst case beat and each burst
  localparam int LIMIT_CYC = ((N_WR + N_RD) * (MAX_LEN + 1) + N_WR + N_RD) * 40;

  logic                   clk = 1'b0;
  logic                   rst_n;
  logic                   aw_valid;
  logic                   aw_ready;
  logic [`AXI_ID_W-1:0]   aw_id;
  logic [`AXI_LEN_W-1:0]  aw_len;
  logic                   w_valid;
  logic                   w_ready;
  logic [`AXI_DATA_W-1:0] w_data;
  logic                   w_last;
  logic                   b_valid;
  logic                   b_ready;
  logic [`AXI_ID_W-1:0]   b_id;
  logic [1:0]             b_resp;
  logic                   ar_valid;
  logic                   ar_ready;
  logic [`AXI_ID_W-1:0]   ar_id;
  logic [`AXI_LEN_W-1:0]  ar_len;
  logic                   r_valid;
  logic                   r_ready;
  logic [`AXI_ID_W-1:0]   r_id;
  logic [`AXI_DATA_W-1:0] r_data;
  logic [1:0]             r_resp;
  logic                   r_last;
  logic [`CSR_ADDR_W-1:0] reg_addr;
  logic [`AXI_DATA_W-1:0] reg_wdata;
  logic                   reg_we;
  logic [`AXI_DATA_W-1:0] reg_rdata;

  // reference model state
  integer                 seed;
  logic [`AXI_ID_W-1:0]   exp_b_id [$];
  logic [`AXI_ID_W-1:0]   exp_r_id [$];
  int                     exp_r_len [$];
  int                     w_len_q [$];
  logic [`AXI_DATA_W-1:0] fill_model;
  int                     wcnt_model;
  int                     rcnt_model;

  always #5 clk = ~clk;

  axi_decerr_sub uut (
    .clk_i       ( clk       ), .rst_ni      ( rst_n     ),
    .aw_valid_i  ( aw_valid  ), .aw_ready_o  ( aw_ready  ),
    .aw_id_i     ( aw_id     ), .aw_len_i    ( aw_len    ),
    .w_valid_i   ( w_valid   ), .w_ready_o   ( w_ready   ),
    .w_data_i    ( w_data    ), .w_last_i    ( w_last    ),
    .b_valid_o   ( b_valid   ), .b_ready_i   ( b_ready   ),
    .b_id_o      ( b_id      ), .b_resp_o    ( b_resp    ),
    .ar_valid_i  ( ar_valid  ), .ar_ready_o  ( ar_ready  ),
    .ar_id_i     ( ar_id     ), .ar_len_i    ( ar_len    ),
    .r_valid_o   ( r_valid   ), .r_ready_i   ( r_ready   ),
    .r_id_o      ( r_id      ), .r_data_o    ( r_data    ),
    .r_resp_o    ( r_resp    ), .r_last_o    ( r_last    ),
    .reg_addr_i  ( reg_addr  ), .reg_wdata_i ( reg_wdata ),
    .reg_we_i    ( reg_we    ), .reg_rdata_o ( reg_rdata )
  );

  function automatic logic [31:0] next_rand();
    next_rand = $random(seed);
  endfunction

  task automatic check(input logic [31:0] actual, input logic [31:0] expected,
                       input string msg);
    if (actual !== expected) begin
      $display("error %0t: %s (got %h, expected %h)", $time, msg, actual, expected);
      $display("TEST FAIL");
      $fatal(1);
    end
  endtask

  // --------------------------------------------------
  // register port access
  // --------------------------------------------------
  task automatic reg_write(input logic [`CSR_ADDR_W-1:0] addr, input logic [31:0] data);
    @(posedge clk);
    #1;
    reg_we    = 1'b1;
    reg_addr  = addr;
    reg_wdata = data;
    @(posedge clk);
    #1;
    reg_we    = 1'b0;
  endtask

  // read port is combinational
  task automatic reg_expect(input logic [`CSR_ADDR_W-1:0] addr, input logic [31:0] exp,
                            input string msg);
    @(posedge clk);
    #1;
    reg_addr = addr;
    #1;
    check(reg_rdata, exp, msg);
  endtask

  // no response may remain once the model is drained
  task automatic expect_drained();
    @(posedge clk);
    #1;
    b_ready = 1'b0;
    r_ready = 1'b0;
    repeat (4) @(posedge clk);
    #1;
    check(32'(b_valid), 32'd0, "extra b response");
    check(32'(r_valid), 32'd0, "extra r beat");
    check(32'(w_ready), 32'd0, "w ready with no burst open");
  endtask

  // --------------------------------------------------
  // random bursts on both channels
  // --------------------------------------------------
  // sample at the falling edge and drive 1 ns after the rising edge
  task automatic run_traffic(input int n_wr, input int n_rd);
    int                     aw_sent;
    int                     ar_sent;
    int                     w_beat;
    int                     r_beat;
    int                     w_done;
    int                     b_seen;
    logic                   hold_b;
    logic                   hold_r;
    logic [`AXI_ID_W-1:0]   prev_b_id;
    logic [`AXI_ID_W-1:0]   prev_r_id;
    logic [`AXI_DATA_W-1:0] prev_r_data;
    logic                   prev_r_last;
    logic                   aw_hs;
    logic                   w_hs;
    logic                   ar_hs;
    logic [31:0]            rnd;
    aw_sent = 0;
    ar_sent = 0;
    w_beat  = 0;
    r_beat  = 0;
    w_done  = 0;
    b_seen  = 0;
    hold_b  = 1'b0;
    hold_r  = 1'b0;
    while (aw_sent < n_wr || ar_sent < n_rd || aw_valid || ar_valid ||
           w_len_q.size() != 0 || exp_b_id.size() != 0 || exp_r_id.size() != 0) begin
      @(negedge clk);
      // b stalled last cycle must still be there
      if (hold_b) begin
        check(32'(b_valid), 32'd1, "b valid dropped while stalled");
        check(32'(b_id), 32'(prev_b_id), "b id changed while stalled");
      end
      // head burst must have seen its last w beat
      if (b_valid) begin
        check(32'(b_seen < w_done), 32'd1, "b before last w beat");
      end
      if (b_valid && b_ready) begin
        check(32'(exp_b_id.size() != 0), 32'd1, "b with nothing outstanding");
        check(32'(b_id), 32'(exp_b_id.pop_front()), "b id out of order");
        check(32'(b_resp), 32'(axi_err_pkg::DECERR), "b resp");
        b_seen++;
        wcnt_model++;
      end
      hold_b    = b_valid && !b_ready;
      prev_b_id = b_id;
      if (hold_r) begin
        check(32'(r_valid), 32'd1, "r valid dropped while stalled");
        check(32'(r_id), 32'(prev_r_id), "r id changed while stalled");
        check(r_data, prev_r_data, "r data changed while stalled");
        check(32'(r_last), 32'(prev_r_last), "r last changed while stalled");
      end
      if (r_valid && r_ready) begin
        check(32'(exp_r_id.size() != 0), 32'd1, "r beat with nothing outstanding");
        check(32'(r_id), 32'(exp_r_id[0]), "r id");
        check(32'(r_resp), 32'(axi_err_pkg::DECERR), "r resp");
        check(r_data, fill_model, "r data not the fill word");
        check(32'(r_last), 32'(r_beat == exp_r_len[0]), "r last placement");
        if (r_beat == exp_r_len[0]) begin
          void'(exp_r_id.pop_front());
          void'(exp_r_len.pop_front());
          r_beat = 0;
          rcnt_model++;
        end else begin
          r_beat++;
        end
      end
      hold_r      = r_valid && !r_ready;
      prev_r_id   = r_id;
      prev_r_data = r_data;
      prev_r_last = r_last;
      // requests taken at the coming edge
      aw_hs = aw_valid && aw_ready;
      w_hs  = w_valid && w_ready;
      ar_hs = ar_valid && ar_ready;
      if (aw_hs) begin
        exp_b_id.push_back(aw_id);
        w_len_q.push_back(int'(aw_len));
      end
      if (w_hs && w_last) begin
        void'(w_len_q.pop_front());
        w_beat = 0;
        w_done++;
      end else if (w_hs) begin
        w_beat++;
      end
      if (ar_hs) begin
        exp_r_id.push_back(ar_id);
        exp_r_len.push_back(int'(ar_len));
      end
      @(posedge clk);
      #1;
      rnd = next_rand();
      if (aw_hs || !aw_valid) begin
        aw_valid = (aw_sent < n_wr) && rnd[20];
        aw_id    = rnd[7:4];
        aw_len   = {4'b0, rnd[11:8]};
        if (aw_valid) aw_sent++;
      end
      // w beats follow their aw in order
      if (w_hs || !w_valid) begin
        w_valid = (w_len_q.size() != 0) && (rnd[21] || rnd[22]);
        w_data  = next_rand();
        w_last  = w_valid && (w_beat == w_len_q[0]);
      end
      if (ar_hs || !ar_valid) begin
        ar_valid = (ar_sent < n_rd) && rnd[23];
        ar_id    = rnd[15:12];
        ar_len   = {4'b0, rnd[19:16]};
        if (ar_valid) ar_sent++;
      end
      b_ready = rnd[24] || rnd[25];
      r_ready = rnd[26] || rnd[27];
    end
  endtask

  initial begin
    seed      = 32'h5a70684f;
    rst_n     = 1'b0;
    aw_valid  = 1'b0;
    aw_id     = '0;
    aw_len    = '0;
    w_valid   = 1'b0;
    w_data    = '0;
    w_last    = 1'b0;
    b_ready   = 1'b0;
    ar_valid  = 1'b0;
    ar_id     = '0;
    ar_len    = '0;
    r_ready   = 1'b0;
    reg_addr  = '0;
    reg_wdata = '0;
    reg_we    = 1'b0;
    fill_model = `ERR_FILL_RST;
    wcnt_model = 0;
    rcnt_model = 0;
    repeat (4) @(posedge clk);
    #1;
    rst_n = 1'b1;
    // idle state after reset
    check(32'(aw_ready), 32'd1, "aw ready after reset");
    check(32'(ar_ready), 32'd1, "ar ready after reset");
    check(32'(w_ready), 32'd0, "w ready after reset");
    check(32'(b_valid), 32'd0, "b valid after reset");
    check(32'(r_valid), 32'd0, "r valid after reset");
    reg_expect(axi_err_pkg::CSR_FILL, `ERR_FILL_RST, "fill reset value");
    reg_expect(axi_err_pkg::CSR_WCNT, 32'd0, "write count reset value");
    reg_expect(axi_err_pkg::CSR_RCNT, 32'd0, "read count reset value");
    reg_expect(2'd3, 32'd0, "unused address");

    run_traffic(N_WR / 2, N_RD / 2);
    reg_expect(axi_err_pkg::CSR_WCNT, wcnt_model, "write count");
    reg_expect(axi_err_pkg::CSR_RCNT, rcnt_model, "read count");

    // new fill word with no read in flight
    fill_model = next_rand();
    reg_write(axi_err_pkg::CSR_FILL, fill_model);
    reg_expect(axi_err_pkg::CSR_FILL, fill_model, "fill readback");
    reg_write(axi_err_pkg::CSR_WCNT, next_rand());
    reg_write(axi_err_pkg::CSR_RCNT, next_rand());
    reg_expect(axi_err_pkg::CSR_WCNT, 32'd0, "write count clear");
    reg_expect(axi_err_pkg::CSR_RCNT, 32'd0, "read count clear");
    wcnt_model = 0;
    rcnt_model = 0;

    run_traffic(N_WR - N_WR / 2, N_RD - N_RD / 2);
    reg_expect(axi_err_pkg::CSR_WCNT, wcnt_model, "write count");
    reg_expect(axi_err_pkg::CSR_RCNT, rcnt_model, "read count");
    expect_drained();
    $display("TEST PASS");
    $finish;
  end

  // watchdog
  initial begin
    repeat (LIMIT_CYC) @(posedge clk);
    $display("timeout: responses missing");
    $display("TEST FAIL");
    $fatal(1);
  end

endmodule

`default_nettype wire

// File: all.f
+incdir+hdl
hdl/axi_err_pkg.sv
hdl/err_fifo.sv
hdl/err_write_path.sv
hdl/err_read_path.sv
hdl/err_csr.sv
hdl/axi_decerr_sub.sv
tests/tb_axi_decerr_sub.sv

// File: Makefile
# Verilator build and run of the testbench

TOP  := tb_axi_decerr_sub
SRCS := $(wildcard hdl/*.sv hdl/*.svh tests/*.sv)

.PHONY: all run clean

all: obj_dir/V$(TOP)

# rebuilt only when a source or the file list changes
obj_dir/V$(TOP): all.f $(SRCS)
	verilator --binary -j 0 --top-module $(TOP) -f all.f

# fails unless the pass line shows up in the output
run: obj_dir/V$(TOP)
	@out="$$(./obj_dir/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "TEST PASS"

clean:
	rm -rf obj_dir
